//--- ftb_cfg_pkg.sv
package ftb_cfg_pkg;

    // fetch address width
    localparam int PC_BITS = 32;

    // tag sits directly above the set index
    localparam int FTB_TAG_BITS = 16;

    // word aligned fetch, set index starts at this bit
    localparam int FTB_OFS_BITS = 2;

    typedef logic [PC_BITS-1:0] pc_t;
    typedef logic [FTB_TAG_BITS-1:0] ftb_tag_t;

    // set index of a fetch address, returned zero extended
    function automatic pc_t pc_set_idx(pc_t pc, int idx_bits);
        pc_t mask;
        mask = (pc_t'(1) << idx_bits) - pc_t'(1);
        return (pc >> FTB_OFS_BITS) & mask;
    endfunction

    // tag of a fetch address for a table with 2**idx_bits sets
    function automatic ftb_tag_t pc_tag(pc_t pc, int idx_bits);
        pc_t shifted;
        shifted = pc >> (FTB_OFS_BITS + idx_bits);
        return shifted[FTB_TAG_BITS-1:0];
    endfunction

endpackage

//--- ftb_info_pkg.sv
package ftb_info_pkg;

    import ftb_cfg_pkg::*;

    // kind of the first branch in the fetch block
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_COND = 3'd1,
        BR_JUMP = 3'd2,
        BR_CALL = 3'd3,
        BR_RET  = 3'd4
    } br_type_e;

    localparam int BR_OFS_BITS = 4;
    localparam int FT_LEN_BITS = 4;
    localparam int TGT_LO_BITS = 19;
    localparam int CTR_BITS    = 2;

    // branch position in words from the block start
    typedef logic [BR_OFS_BITS-1:0] br_ofs_t;
    // block length in words, zero stands for a full block
    typedef logic [FT_LEN_BITS-1:0] ft_len_t;
    // target word address bits 20 down to 2
    typedef logic [TGT_LO_BITS-1:0] tgt_lo_t;
    // 2-bit saturating taken counter
    typedef logic [CTR_BITS-1:0] ctr_t;

    // 32-bit descriptor of the first branch in a fetch block
    typedef struct packed {
        br_type_e br_type;
        br_ofs_t  br_offset;
        ft_len_t  fallthru_len;
        tgt_lo_t  target_lo;
        ctr_t     ctr;
    } ftb_info_t;

    // address right after the fetch block
    function automatic pc_t calc_fallthru(pc_t start_pc, ftb_info_t info);
        pc_t len_words;
        if (info.fallthru_len == '0) begin
            len_words = pc_t'(1) << FT_LEN_BITS;
        end else begin
            len_words = pc_t'(info.fallthru_len);
        end
        return start_pc + (len_words << FTB_OFS_BITS);
    endfunction

    // upper bits come from the block start, low bits from the descriptor
    function automatic pc_t calc_target(pc_t start_pc, ftb_info_t info);
        return {
            start_pc[PC_BITS-1:TGT_LO_BITS+FTB_OFS_BITS],
            info.target_lo,
            {FTB_OFS_BITS{1'b0}}
        };
    endfunction

endpackage

//--- ftb_plru.sv
module ftb_plru #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_touch_en,
    input  logic [$clog2(SETS)-1:0] i_touch_set,
    input  logic [$clog2(WAYS)-1:0] i_touch_way,
    input  logic [$clog2(SETS)-1:0] i_query_set,
    output logic [$clog2(WAYS)-1:0] o_victim_way
);

    localparam int WAY_BITS = $clog2(WAYS);

    typedef logic [WAY_BITS-1:0] way_idx_t;
    typedef logic [WAYS-2:0] tree_t;

    // heap layout, node n at bit n-1, root is node 1
    // a bit of 0 sends the victim search to the lower half
    tree_t tree_q [SETS];

    // point every node on the path away from the touched way
    function automatic tree_t tree_touch(tree_t tree, way_idx_t way);
        int   node;
        logic dir;
        node = 1;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            dir = way[WAY_BITS-1-lvl];
            tree[node-1] = ~dir;
            node = 2 * node + int'(dir);
        end
        return tree;
    endfunction

    // walk from the root following the node bits
    function automatic way_idx_t tree_victim(tree_t tree);
        way_idx_t way;
        int       node;
        way = '0;
        node = 1;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            way[WAY_BITS-1-lvl] = tree[node-1];
            node = 2 * node + int'(tree[node-1]);
        end
        return way;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (i_touch_en) begin
            tree_q[i_touch_set] <= tree_touch(tree_q[i_touch_set], i_touch_way);
        end
    end

    // victim reflects the state before any touch in this cycle
    assign o_victim_way = tree_victim(tree_q[i_query_set]);

endmodule

//--- ftb_sram.sv
module ftb_sram
    import ftb_cfg_pkg::*;
    import ftb_info_pkg::*;
#(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_squash_vld,
    input  logic      i_lookup_vld,
    input  pc_t       i_lookup_pc,
    input  logic      i_update_vld,
    input  pc_t       i_update_pc,
    input  logic      i_write_en,
    input  ftb_info_t i_write_info,
    output ftb_info_t o_lookup_info,
    output logic      o_lookup_hit,
    output logic      o_lookup_hit_rdy
);

    localparam int IDX_BITS = $clog2(SETS);
    localparam int WAY_BITS = $clog2(WAYS);

    typedef logic [IDX_BITS-1:0] set_idx_t;
    typedef logic [WAY_BITS-1:0] way_idx_t;

    // decoded lookup address
    typedef struct packed {
        set_idx_t idx;
        ftb_tag_t tag;
    } lkp_addr_t;

    // snapshot of the target set taken when an update is accepted
    typedef struct packed {
        set_idx_t               idx;
        ftb_tag_t               tag;
        logic [WAYS-1:0]        way_vld;
        ftb_tag_t [WAYS-1:0]    way_tag;
    } upd_ctx_t;

    // way arrays
    logic [WAYS-1:0] vld_q  [SETS];
    ftb_tag_t        tag_q  [SETS][WAYS];
    ftb_info_t       info_q [SETS][WAYS];

    // lookup pipeline
    logic            s1_vld_q;
    lkp_addr_t       s1_addr_q;
    logic [WAYS-1:0] s1_hit_vec;
    way_idx_t        s1_hit_way;
    logic            s2_vld_q;
    logic            s2_hit_q;
    ftb_info_t       s2_info_q;
    set_idx_t        s2_idx_q;
    way_idx_t        s2_way_q;

    // update path
    upd_ctx_t        upd_q;
    logic [WAYS-1:0] upd_hit_vec;
    way_idx_t        wr_way;
    way_idx_t        victim_way;

    // replacement touch
    logic            touch_en;
    set_idx_t        touch_set;
    way_idx_t        touch_way;

    // lowest set bit of a way vector
    function automatic way_idx_t first_way(logic [WAYS-1:0] vec);
        way_idx_t way;
        way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (vec[w]) begin
                way = way_idx_t'(w);
            end
        end
        return way;
    endfunction

    // s1 reads all ways of the set and compares tags
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            s1_hit_vec[w] = vld_q[s1_addr_q.idx][w]
                && (tag_q[s1_addr_q.idx][w] == s1_addr_q.tag);
        end
        s1_hit_way = first_way(s1_hit_vec);
    end

    // squash drops whatever is in s1 and s2
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
            s2_hit_q <= 1'b0;
        end else begin
            s1_vld_q <= i_lookup_vld && !i_squash_vld;
            s2_vld_q <= s1_vld_q && !i_squash_vld;
            s2_hit_q <= s1_vld_q && !i_squash_vld && (|s1_hit_vec);
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup_vld) begin
            s1_addr_q.idx <= set_idx_t'(pc_set_idx(i_lookup_pc, IDX_BITS));
            s1_addr_q.tag <= pc_tag(i_lookup_pc, IDX_BITS);
        end
        s2_info_q <= info_q[s1_addr_q.idx][s1_hit_way];
        s2_idx_q  <= s1_addr_q.idx;
        s2_way_q  <= s1_hit_way;
    end

    assign o_lookup_hit_rdy = s2_vld_q;
    assign o_lookup_hit     = s2_hit_q;
    assign o_lookup_info    = s2_info_q;

    // capture the set at accept, the write follows next cycle
    always_ff @(posedge clk) begin
        if (i_update_vld) begin
            upd_q.idx     <= set_idx_t'(pc_set_idx(i_update_pc, IDX_BITS));
            upd_q.tag     <= pc_tag(i_update_pc, IDX_BITS);
            upd_q.way_vld <= vld_q[set_idx_t'(pc_set_idx(i_update_pc, IDX_BITS))];
            for (int w = 0; w < WAYS; w++) begin
                upd_q.way_tag[w] <= tag_q[set_idx_t'(pc_set_idx(i_update_pc, IDX_BITS))][w];
            end
        end
    end

    // way choice: matching tag, then lowest invalid, then plru victim
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            upd_hit_vec[w] = upd_q.way_vld[w] && (upd_q.way_tag[w] == upd_q.tag);
        end
        if (|upd_hit_vec) begin
            wr_way = first_way(upd_hit_vec);
        end else if (!(&upd_q.way_vld)) begin
            wr_way = first_way(~upd_q.way_vld);
        end else begin
            wr_way = victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                vld_q[s] <= '0;
            end
        end else if (i_write_en) begin
            vld_q[upd_q.idx][wr_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_write_en) begin
            tag_q[upd_q.idx][wr_way]  <= upd_q.tag;
            info_q[upd_q.idx][wr_way] <= i_write_info;
        end
    end

    // write touch takes priority over a lookup hit in the same cycle
    assign touch_en  = i_write_en || s2_hit_q;
    assign touch_set = i_write_en ? upd_q.idx : s2_idx_q;
    assign touch_way = i_write_en ? wr_way : s2_way_q;

    ftb_plru #(
        .SETS (SETS),
        .WAYS (WAYS)
    ) u_plru (
        .clk          (clk),
        .rst          (rst),
        .i_touch_en   (touch_en),
        .i_touch_set  (touch_set),
        .i_touch_way  (touch_way),
        .i_query_set  (upd_q.idx),
        .o_victim_way (victim_way)
    );

endmodule

//--- ftb.sv
module ftb
    import ftb_cfg_pkg::*;
    import ftb_info_pkg::*;
#(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_squash_vld,

    // lookup port, one-cycle req/gnt
    input  logic      i_lookup_req,
    input  pc_t       i_lookup_pc,
    output logic      o_lookup_gnt,
    output ftb_info_t o_lookup_info,
    output logic      o_lookup_hit,
    output logic      o_lookup_hit_rdy,
    output pc_t       o_lookup_fallthru,
    output pc_t       o_lookup_target,

    // update port, req held until finished
    input  logic      i_update_req,
    input  pc_t       i_update_pc,
    input  ftb_info_t i_update_info,
    output logic      o_update_finished
);

    // lookup: s0 request, s1 read all ways, s2 output
    // update: s0 accept and read the set, s1 pick a way and write

    typedef enum logic {
        ST_NORMAL,
        ST_UPDATING
    } status_e;

    status_e   status_q;
    logic      upd_accept;
    logic      write_en;
    ftb_info_t upd_info_q;

    // lookup address follows the storage pipeline
    pc_t       s1_pc_q;
    pc_t       s2_pc_q;

    assign upd_accept = (status_q == ST_NORMAL) && i_update_req;
    assign write_en   = (status_q == ST_UPDATING);

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= ST_NORMAL;
        end else begin
            case (status_q)
                ST_NORMAL: begin
                    if (i_update_req) begin
                        status_q <= ST_UPDATING;
                    end
                end
                // always a single write cycle
                ST_UPDATING: status_q <= ST_NORMAL;
                default:     status_q <= ST_NORMAL;
            endcase
        end
    end

    // descriptor is held from accept to the write cycle
    always_ff @(posedge clk) begin
        if (upd_accept) begin
            upd_info_q <= i_update_info;
        end
    end

    always_ff @(posedge clk) begin
        if (o_lookup_gnt) begin
            s1_pc_q <= i_lookup_pc;
        end
        s2_pc_q <= s1_pc_q;
    end

    // no lookups while an update is pending or being written
    assign o_lookup_gnt = i_lookup_req && !i_update_req
        && (status_q == ST_NORMAL) && !i_squash_vld;

    assign o_update_finished = write_en;

    ftb_sram #(
        .SETS (SETS),
        .WAYS (WAYS)
    ) u_sram (
        .clk              (clk),
        .rst              (rst),
        .i_squash_vld     (i_squash_vld),
        .i_lookup_vld     (o_lookup_gnt),
        .i_lookup_pc      (i_lookup_pc),
        .i_update_vld     (upd_accept),
        .i_update_pc      (i_update_pc),
        .i_write_en       (write_en),
        .i_write_info     (upd_info_q),
        .o_lookup_info    (o_lookup_info),
        .o_lookup_hit     (o_lookup_hit),
        .o_lookup_hit_rdy (o_lookup_hit_rdy)
    );

    // derived addresses, only meaningful on a hit
    assign o_lookup_fallthru = calc_fallthru(s2_pc_q, o_lookup_info);
    assign o_lookup_target   = calc_target(s2_pc_q, o_lookup_info);

endmodule

//--- ftb_tb.sv
module ftb_tb
    import ftb_cfg_pkg::*;
    import ftb_info_pkg::*;
();

    localparam int TB_SETS    = 16;
    localparam int TB_WAYS    = 4;
    localparam int MAX_CYCLES = 4000;

    // expected content of one lookup stage
    typedef struct packed {
        logic       vld;
        logic       hit;
        logic [1:0] way;
        pc_t        pc;
        ftb_info_t  info;
    } exp_t;

    // one way of the shadow table
    typedef struct packed {
        logic      vld;
        ftb_tag_t  tag;
        ftb_info_t info;
    } shadow_way_t;

    logic      clk;
    logic      rst;
    logic      i_squash_vld;
    logic      i_lookup_req;
    pc_t       i_lookup_pc;
    logic      i_update_req;
    pc_t       i_update_pc;
    ftb_info_t i_update_info;
    logic      o_lookup_gnt;
    ftb_info_t o_lookup_info;
    logic      o_lookup_hit;
    logic      o_lookup_hit_rdy;
    pc_t       o_lookup_fallthru;
    pc_t       o_lookup_target;
    logic      o_update_finished;

    shadow_way_t shadow [TB_SETS][TB_WAYS];
    // bit 0 root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0]  plru_bits [TB_SETS];
    exp_t        exp1;
    exp_t        exp2;
    pc_t         acc_pc;
    ftb_info_t   acc_info;
    logic        accepted_q;
    // grant expected from the handshake rules
    logic        exp_gnt;
    int          hit_cnt = 0;
    int          miss_cnt = 0;
    int          squash_cnt = 0;
    int          cycles = 0;
    pc_t         lkp_q [$];

    ftb #(
        .SETS (TB_SETS),
        .WAYS (TB_WAYS)
    ) dut (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .i_lookup_req      (i_lookup_req),
        .i_lookup_pc       (i_lookup_pc),
        .o_lookup_gnt      (o_lookup_gnt),
        .o_lookup_info     (o_lookup_info),
        .o_lookup_hit      (o_lookup_hit),
        .o_lookup_hit_rdy  (o_lookup_hit_rdy),
        .o_lookup_fallthru (o_lookup_fallthru),
        .o_lookup_target   (o_lookup_target),
        .i_update_req      (i_update_req),
        .i_update_pc       (i_update_pc),
        .i_update_info     (i_update_info),
        .o_update_finished (o_update_finished)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign exp_gnt = i_lookup_req && !i_update_req && !accepted_q && !i_squash_vld;

    function automatic logic [3:0] set_of(pc_t pc);
        return pc[5:2];
    endfunction

    function automatic ftb_tag_t tag_of(pc_t pc);
        return pc[21:6];
    endfunction

    // block start plus its length in bytes
    function automatic pc_t next_fallthru(pc_t pc, ftb_info_t info);
        pc_t words;
        words = (info.fallthru_len == 4'd0) ? 32'd16 : {28'd0, info.fallthru_len};
        return pc + words * 32'd4;
    endfunction

    function automatic pc_t branch_target(pc_t pc, ftb_info_t info);
        return {pc[31:21], info.target_lo, 2'b00};
    endfunction

    function automatic pc_t make_pc(logic [3:0] set);
        logic [9:0] upper;
        ftb_tag_t   tag;
        upper = 10'($urandom);
        tag   = ftb_tag_t'($urandom);
        return {upper, tag, set, 2'b00};
    endfunction

    function automatic ftb_info_t rand_info();
        ftb_info_t info;
        info = ftb_info_t'($urandom);
        info.br_type = br_type_e'($urandom_range(1, 4));
        return info;
    endfunction

    function automatic logic [1:0] pick_victim(logic [2:0] bits);
        if (!bits[0]) begin
            return bits[1] ? 2'd1 : 2'd0;
        end
        return bits[2] ? 2'd3 : 2'd2;
    endfunction

    // aim the tree away from the way just used
    task automatic touch_tree(logic [3:0] set, logic [1:0] way);
        if (way < 2'd2) begin
            plru_bits[set][0] = 1'b1;
            plru_bits[set][1] = (way == 2'd0);
        end else begin
            plru_bits[set][0] = 1'b0;
            plru_bits[set][2] = (way == 2'd2);
        end
    endtask

    task automatic write_shadow(pc_t pc, ftb_info_t info);
        logic [3:0] set;
        ftb_tag_t   tag;
        int         way;
        set = set_of(pc);
        tag = tag_of(pc);
        way = -1;
        for (int w = 0; w < TB_WAYS; w++) begin
            if (way < 0 && shadow[set][w].vld && shadow[set][w].tag == tag) begin
                way = w;
            end
        end
        for (int w = 0; w < TB_WAYS; w++) begin
            if (way < 0 && !shadow[set][w].vld) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = int'(pick_victim(plru_bits[set]));
        end
        shadow[set][way] = '{vld: 1'b1, tag: tag, info: info};
        touch_tree(set, 2'(way));
    endtask

    function automatic exp_t predict_lookup(logic vld, pc_t pc);
        exp_t       e;
        logic [3:0] set;
        e     = '0;
        e.vld = vld;
        e.pc  = pc;
        set   = set_of(pc);
        for (int w = 0; w < TB_WAYS; w++) begin
            if (vld && !e.hit && shadow[set][w].vld && shadow[set][w].tag == tag_of(pc)) begin
                e.hit  = 1'b1;
                e.way  = 2'(w);
                e.info = shadow[set][w].info;
            end
        end
        return e;
    endfunction

    // shadow model, advanced on every rising edge
    always @(posedge clk) begin
        if (rst) begin
            exp1       <= '0;
            exp2       <= '0;
            accepted_q <= 1'b0;
            for (int s = 0; s < TB_SETS; s++) begin
                plru_bits[s] = '0;
                for (int w = 0; w < TB_WAYS; w++) begin
                    shadow[s][w] = '0;
                end
            end
        end else begin
            // a write touch hides a lookup touch in the same cycle
            if (accepted_q) begin
                write_shadow(acc_pc, acc_info);
            end else if (exp2.vld && exp2.hit) begin
                touch_tree(set_of(exp2.pc), exp2.way);
            end
            if (exp2.vld && exp2.hit) begin
                hit_cnt++;
            end else if (exp2.vld) begin
                miss_cnt++;
            end
            if (i_squash_vld && exp1.vld) begin
                squash_cnt++;
            end
            accepted_q <= i_update_req && !accepted_q;
            if (i_update_req && !accepted_q) begin
                acc_pc   <= i_update_pc;
                acc_info <= i_update_info;
            end
            exp1     <= predict_lookup(exp_gnt, i_lookup_pc);
            exp2     <= exp1;
            exp2.vld <= exp1.vld && !i_squash_vld;
            exp2.hit <= exp1.hit && !i_squash_vld;
        end
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "check on %s failed", name);
    endtask

    a_gnt: assert property (@(posedge clk) disable iff (rst)
        o_lookup_gnt == exp_gnt)
        else report_mismatch("o_lookup_gnt", $sampled(exp_gnt), $sampled(o_lookup_gnt));

    a_finished: assert property (@(posedge clk) disable iff (rst)
        o_update_finished == accepted_q)
        else report_mismatch("o_update_finished", $sampled(accepted_q),
            $sampled(o_update_finished));

    a_hit_rdy: assert property (@(posedge clk) disable iff (rst)
        o_lookup_hit_rdy == exp2.vld)
        else report_mismatch("o_lookup_hit_rdy", $sampled(exp2.vld), $sampled(o_lookup_hit_rdy));

    a_hit: assert property (@(posedge clk) disable iff (rst)
        exp2.vld |-> o_lookup_hit == exp2.hit)
        else report_mismatch("o_lookup_hit", $sampled(exp2.hit), $sampled(o_lookup_hit));

    a_info: assert property (@(posedge clk) disable iff (rst)
        (exp2.vld && exp2.hit) |-> o_lookup_info == exp2.info)
        else report_mismatch("o_lookup_info", $sampled(exp2.info), $sampled(o_lookup_info));

    a_fallthru: assert property (@(posedge clk) disable iff (rst)
        (exp2.vld && exp2.hit) |-> o_lookup_fallthru == next_fallthru(exp2.pc, exp2.info))
        else report_mismatch("o_lookup_fallthru", $sampled(next_fallthru(exp2.pc, exp2.info)),
            $sampled(o_lookup_fallthru));

    a_target: assert property (@(posedge clk) disable iff (rst)
        (exp2.vld && exp2.hit) |-> o_lookup_target == branch_target(exp2.pc, exp2.info))
        else report_mismatch("o_lookup_target", $sampled(branch_target(exp2.pc, exp2.info)),
            $sampled(o_lookup_target));

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // issue every queued pc, each held until granted
    task automatic run_lookups();
        pc_t pc;
        while (lkp_q.size() > 0) begin
            pc = lkp_q.pop_front();
            i_lookup_req = 1'b1;
            i_lookup_pc  = pc;
            @(negedge clk);
            while (!o_lookup_gnt) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        i_lookup_req = 1'b0;
    endtask

    task automatic send_update(pc_t pc, ftb_info_t info);
        i_update_req  = 1'b1;
        i_update_pc   = pc;
        i_update_info = info;
        @(negedge clk);
        while (!o_update_finished) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        i_update_req = 1'b0;
    endtask

    // squash lands in the cycle right after the grant
    task automatic squash_after_grant(pc_t pc);
        i_lookup_req = 1'b1;
        i_lookup_pc  = pc;
        @(negedge clk);
        while (!o_lookup_gnt) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        i_lookup_req = 1'b0;
        i_squash_vld = 1'b1;
        @(posedge clk);
        #1;
        i_squash_vld = 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        #1;
        while (exp1.vld || exp2.vld) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        pc_t       blk_pcs [8];
        pc_t       evict_pcs [5];
        ftb_info_t info;
        void'($urandom(19));
        rst           = 1'b1;
        i_squash_vld  = 1'b0;
        i_lookup_req  = 1'b0;
        i_lookup_pc   = '0;
        i_update_req  = 1'b0;
        i_update_pc   = '0;
        i_update_info = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // empty table, everything misses
        for (int i = 0; i < 6; i++) begin
            lkp_q.push_back(make_pc(4'($urandom_range(0, 15))));
        end
        run_lookups();
        wait_drained();

        // lookup held while an update goes through, then hits
        blk_pcs[0]   = make_pc(4'd0);
        i_lookup_req = 1'b1;
        i_lookup_pc  = blk_pcs[0];
        send_update(blk_pcs[0], rand_info());
        lkp_q.push_back(blk_pcs[0]);
        run_lookups();
        wait_drained();

        // fill sets 0 to 7, one entry with a full-length block
        for (int i = 1; i < 8; i++) begin
            blk_pcs[i] = make_pc(4'(i));
            info = rand_info();
            if (i == 1) begin
                info.fallthru_len = '0;
            end
            send_update(blk_pcs[i], info);
        end
        for (int i = 0; i < 8; i++) begin
            lkp_q.push_back(blk_pcs[i]);
        end
        run_lookups();
        wait_drained();

        // back to back, hits and misses interleaved
        for (int i = 0; i < 8; i++) begin
            lkp_q.push_back(blk_pcs[i]);
            lkp_q.push_back(make_pc(4'(i)));
        end
        run_lookups();
        wait_drained();

        // five tags into set 9, the first one is evicted
        for (int i = 0; i < 5; i++) begin
            evict_pcs[i] = make_pc(4'd9);
            send_update(evict_pcs[i], rand_info());
        end
        for (int i = 0; i < 5; i++) begin
            lkp_q.push_back(evict_pcs[i]);
        end
        run_lookups();
        wait_drained();

        // rewrite of a resident tag stays in its way
        send_update(evict_pcs[2], rand_info());
        for (int i = 1; i < 5; i++) begin
            lkp_q.push_back(evict_pcs[i]);
        end
        run_lookups();
        wait_drained();

        squash_after_grant(blk_pcs[3]);
        wait_drained();
        lkp_q.push_back(blk_pcs[3]);
        run_lookups();
        wait_drained();

        if (hit_cnt == 0 || miss_cnt == 0 || squash_cnt == 0) begin
            $display("the sequence produced no hit, no miss or no squashed lookup");
            $display("** FAIL **");
            $fatal(1, "stimulus incomplete");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- src.f
ftb_cfg_pkg.sv
ftb_info_pkg.sv
ftb_plru.sv
ftb_sram.sv
ftb.sv
ftb_tb.sv

//--- Bender.yml
package:
  name: ftb

dependencies: {}

sources:
  # packages first, then the design bottom up
  - ftb_cfg_pkg.sv
  - ftb_info_pkg.sv
  - ftb_plru.sv
  - ftb_sram.sv
  - ftb.sv

  # testbench, top module ftb_tb
  - target: test
    files:
      - ftb_tb.sv
